// ==== verification/program.hex ====
// one 32-bit instruction word per line, little-endian in memory from address 0
// legal and illegal encodings mixed, comment gives the form
00000537 // lui
00000517 // auipc
0000006f // jal
00008067 // jalr f3 0
00009067 // jalr f3 1, illegal
00208463 // beq
00002083 // lw
00003083 // load f3 3, illegal
00002023 // sw
00003023 // store f3 3, illegal
00109093 // slli
40105093 // srai
40101093 // slli with f7 0x20, illegal
00000073 // ecall
30200073 // mret
00001073 // csrrw
00003073 // csrrc, illegal
ffffffff // illegal
00000013 // addi
00000033 // add

// ==== files.f ====
source/rv_mem_pkg.sv
source/rv32_legal_check.sv
source/fetch_unit.sv
source/load_store_unit.sv
source/bus_arbiter.sv
source/mem_slave.sv
source/fetch_mem_top.sv
verification/tb_fetch_mem.sv

// ==== Makefile ====
# Verilator build and run for the fetch / load-store memory subsystem
VERILATOR ?= verilator
TOP       ?= tb_fetch_mem
RTL_TOP   ?= fetch_mem_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) source/rv_mem_pkg.sv \
		source/rv32_legal_check.sv source/fetch_unit.sv source/load_store_unit.sv \
		source/bus_arbiter.sv source/mem_slave.sv source/fetch_mem_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_fetch_mem.sv ====
/*
 * Self-checking testbench for fetch_mem_top. It plays the execute stage:
 * paces fetches with last_finish_i, drives redirects and load/store
 * commands, and keeps a byte model of memory plus the expected PC.
 * Concurrent assertions compare the DUT outputs against that model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_mem
	import rv_mem_pkg::*;
;

	// about 150 bus operations of up to ~12 cycles each, plus finish gaps
	localparam int MAX_CYCLES = 4000;

	logic clk = 1'b0;
	logic rst, last_finish_i, trap_i, jump_i, branch_taken_i;
	logic [31:0] trap_pc_i, jump_target_i, branch_target_i;
	logic fetch_valid_o, inst_invalid_o, ls_busy_o, ls_done_o, ls_err_o;
	logic [31:0] inst_o, pc_o, ls_rdata_o;
	logic ls_req_i, ls_we_i, ls_unsigned_i;
	acc_size_e ls_size_i;
	logic [31:0] ls_addr_i, ls_wdata_i;

	logic [7:0]  model [0:1023];
	logic [31:0] prog_words [0:255];
	logic [31:0] exp_pc, exp_inst, exp_rdata;
	logic        exp_invalid, exp_err, exp_is_load;
	int          errors = 0;
	int          cycles = 0;
	int          tests = 0;
	int          failed_tests = 0;
	int          pulses;

	fetch_mem_top UUT (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// fetch pulses seen since the last finish strobe
	always @(posedge clk) begin
		if (rst || last_finish_i)
			pulses <= 0;
		else if (fetch_valid_o)
			pulses <= pulses + 1;
	end

	a_pc: assert property (@(posedge clk) disable iff (rst) fetch_valid_o |-> pc_o == exp_pc)
		else begin
			errors++;
			$display("ERR pc_o exp=%h got=%h", exp_pc, pc_o);
		end
	a_inst: assert property (@(posedge clk) disable iff (rst) fetch_valid_o |-> inst_o == exp_inst)
		else begin
			errors++;
			$display("ERR inst_o exp=%h got=%h", exp_inst, inst_o);
		end
	a_invalid: assert property (@(posedge clk) disable iff (rst)
		fetch_valid_o |-> inst_invalid_o == exp_invalid)
		else begin
			errors++;
			$display("ERR inst_invalid_o exp=%h got=%h", exp_invalid, inst_invalid_o);
		end
	// fetch outputs only change when a new instruction is delivered
	a_hold: assert property (@(posedge clk) disable iff (rst)
		!fetch_valid_o |-> $stable(pc_o) && $stable(inst_o) && $stable(inst_invalid_o))
		else begin
			errors++;
			$display("fetch outputs changed between two fetch pulses");
		end
	a_pulse: assert property (@(posedge clk) disable iff (rst) fetch_valid_o |=> !fetch_valid_o)
		else begin
			errors++;
			$display("fetch_valid_o stayed high for more than one cycle");
		end
	a_one_per_finish: assert property (@(posedge clk) disable iff (rst)
		fetch_valid_o |-> pulses == 0)
		else begin
			errors++;
			$display("second fetch pulse appeared without a finish strobe");
		end
	a_busy_rise: assert property (@(posedge clk) disable iff (rst)
		ls_req_i && !ls_busy_o |=> ls_busy_o)
		else begin
			errors++;
			$display("ls_busy_o did not rise after an accepted request");
		end
	a_busy_fall: assert property (@(posedge clk) disable iff (rst) ls_done_o |=> !ls_busy_o)
		else begin
			errors++;
			$display("ls_busy_o stayed high after ls_done_o");
		end
	a_ls_err: assert property (@(posedge clk) disable iff (rst) ls_done_o |-> ls_err_o == exp_err)
		else begin
			errors++;
			$display("ERR ls_err_o exp=%h got=%h", exp_err, ls_err_o);
		end
	// error completions must return zero data
	a_ls_data: assert property (@(posedge clk) disable iff (rst)
		ls_done_o && exp_is_load |-> ls_rdata_o == exp_rdata)
		else begin
			errors++;
			$display("ERR ls_rdata_o exp=%h got=%h", exp_rdata, ls_rdata_o);
		end

	// supported subset, written out from the opcode table
	function automatic logic ref_legal(input logic [31:0] w);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = w[14:12];
		f7 = w[31:25];
		case (w[6:0])
			7'h37, 7'h17, 7'h6f, 7'h63, 7'h33: return 1'b1;
			7'h67: return f3 == 3'd0;
			7'h03: return f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7;
			7'h23: return f3 < 3'd3;
			7'h13: begin
				if (f3 == 3'd1)
					return f7 == 7'h00;
				if (f3 == 3'd5)
					return f7 == 7'h00 || f7 == 7'h20;
				return 1'b1;
			end
			7'h73: return f3 == 3'd1 || f3 == 3'd2 || w == 32'h0000_0073 ||
				w == 32'h0010_0073 || w == 32'h3020_0073;
			default: return 1'b0;
		endcase
	endfunction

	task automatic set_expected();
		if (exp_pc >= 32'd1024) begin
			exp_inst    = '0;
			exp_invalid = 1'b1;
		end else begin
			exp_inst    = {model[exp_pc+3], model[exp_pc+2], model[exp_pc+1], model[exp_pc]};
			exp_invalid = !ref_legal(exp_inst);
		end
	endtask

	// returns once the pending instruction has been delivered
	task automatic wait_fetch();
		while (pulses == 0)
			@(negedge clk);
	endtask

	// one instruction: wait for it, then finish with the given redirects
	task automatic fetch_step(input bit trap, input bit jmp, input bit br,
		input logic [31:0] tpc, input logic [31:0] jt, input logic [31:0] bt, input bit noise);
		wait_fetch();
		repeat (1 + $urandom % 4) begin
			@(negedge clk);
			trap_i          = noise;
			jump_i          = noise;
			branch_taken_i  = noise;
			trap_pc_i       = 32'h3fc;
			jump_target_i   = 32'h3f8;
			branch_target_i = 32'h3f4;
		end
		@(negedge clk);
		// keep sequential flow inside the loaded program
		if (!(trap || jmp || br) && exp_pc + 4 >= 32'h50) begin
			jmp = 1'b1;
			jt  = 32'h0;
		end
		last_finish_i   = 1'b1;
		trap_i          = trap;
		jump_i          = jmp;
		branch_taken_i  = br;
		trap_pc_i       = tpc;
		jump_target_i   = jt;
		branch_target_i = bt;
		exp_pc = trap ? tpc : jmp ? jt : br ? bt : exp_pc + 4;
		set_expected();
		@(negedge clk);
		last_finish_i  = 1'b0;
		trap_i         = 1'b0;
		jump_i         = 1'b0;
		branch_taken_i = 1'b0;
	endtask

	task automatic ls_op(input bit we, input acc_size_e sz, input bit uns,
		input logic [31:0] addr, input logic [31:0] wdata);
		int n;
		logic [31:0] raw;
		n = (sz == SZ_BYTE) ? 1 : (sz == SZ_HALF) ? 2 : 4;
		exp_err = (sz == SZ_HALF && addr[0]) || (sz == SZ_WORD && addr[1:0] != 2'b00) ||
			addr >= 32'd1024;
		exp_is_load = !we;
		raw = '0;
		for (int i = 0; i < n; i++)
			if (!exp_err)
				raw[8*i +: 8] = model[addr+i];
		if (sz == SZ_BYTE)
			exp_rdata = uns ? {24'h0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
		else if (sz == SZ_HALF)
			exp_rdata = uns ? {16'h0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
		else
			exp_rdata = raw;
		ls_req_i      = 1'b1;
		ls_we_i       = we;
		ls_size_i     = sz;
		ls_unsigned_i = uns;
		ls_addr_i     = addr;
		ls_wdata_i    = wdata;
		@(negedge clk);
		ls_req_i = 1'b0;
		do @(negedge clk); while (!ls_done_o);
		if (we && !exp_err) begin
			for (int i = 0; i < n; i++)
				model[addr+i] = wdata[8*i +: 8];
			if (addr < 32'h50)
				set_expected();
		end
		// let the assertions sample the done cycle first
		@(negedge clk);
	endtask

	// overwrite one program word, then fetch it and return to the start
	task automatic patch_and_fetch(input logic [31:0] word);
		ls_op(1, SZ_WORD, 0, 32'h48, word);
		fetch_step(0, 1, 0, 0, 32'h48, 0, 0);
		fetch_step(0, 1, 0, 0, 32'h0, 0, 0);
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors != err_before)
			failed_tests++;
		$display("test %-16s %s (%0d errors)", name,
			(errors == err_before) ? "ok" : "failing", errors - err_before);
	endtask

	initial begin
		int e;
		logic [31:0] a;
		void'($urandom(32'h3c8e_e6c6));
		rst = 1'b1;
		{last_finish_i, trap_i, jump_i, branch_taken_i, ls_req_i, ls_we_i, ls_unsigned_i} = '0;
		{trap_pc_i, jump_target_i, branch_target_i, ls_addr_i, ls_wdata_i} = '0;
		ls_size_i = SZ_WORD;
		for (int i = 0; i < 256; i++)
			prog_words[i] = '0;
		$readmemh(MEM_INIT_FILE, prog_words);
		for (int i = 0; i < 1024; i++)
			model[i] = prog_words[i/4][8*(i%4) +: 8];
		exp_pc = RESET_PC;
		exp_is_load = 1'b0;
		exp_err = 1'b0;
		exp_rdata = '0;
		set_expected();
		repeat (2) @(negedge clk);
		rst = 1'b0;

		e = errors;
		@(negedge clk);
		assert (!fetch_valid_o && !ls_busy_o && !ls_done_o)
			else begin
				errors++;
				$display("strobes not low after reset");
			end
		assert (pc_o == RESET_PC)
			else begin
				errors++;
				$display("ERR pc_o exp=%h got=%h", RESET_PC, pc_o);
			end
		report_test("reset", e);

		e = errors;
		repeat (24) fetch_step(0, 0, 0, 0, 0, 0, 0);
		report_test("sequential", e);

		e = errors;
		fetch_step(1, 1, 1, 32'h34, 32'h20, 32'h10, 1);
		fetch_step(0, 1, 1, 32'h34, 32'h20, 32'h10, 0);
		fetch_step(0, 0, 1, 32'h34, 32'h20, 32'h10, 1);
		fetch_step(0, 0, 0, 32'h34, 32'h20, 32'h10, 1);
		fetch_step(1, 0, 1, 32'h0c, 32'h20, 32'h10, 0);
		report_test("redirect", e);

		e = errors;
		// fill pattern built from the full byte address
		for (int i = 32'h100; i < 32'h180; i += 4)
			ls_op(1, SZ_WORD, 0, i, i * 32'h9e37_79b1 ^ 32'h5a5a_0000);
		repeat (8) ls_op(1, SZ_BYTE, 0, 32'h100 + $urandom % 128, $urandom);
		repeat (8) ls_op(1, SZ_HALF, 0, 32'h100 + 2 * ($urandom % 64), $urandom);
		repeat (6) begin
			a = 32'h100 + $urandom % 128;
			ls_op(0, SZ_BYTE, 0, a, 0);
			ls_op(0, SZ_BYTE, 1, a, 0);
			ls_op(0, SZ_HALF, 0, a & ~32'h1, 0);
			ls_op(0, SZ_HALF, 1, a & ~32'h1, 0);
			ls_op(0, SZ_WORD, 0, a & ~32'h3, 0);
		end
		// encodings the loaded program lacks, legal and illegal
		patch_and_fetch(32'h0000_7003);
		patch_and_fetch(32'h0010_0073);
		patch_and_fetch(32'h0020_0073);
		patch_and_fetch(32'h0000_2073);
		patch_and_fetch(32'h0000_1083);
		patch_and_fetch(32'h0000_4083);
		patch_and_fetch(32'h0000_5083);
		patch_and_fetch(32'h0000_1023);
		patch_and_fetch(32'h0010_5093);
		report_test("store_load", e);

		e = errors;
		fork
			repeat (4) fetch_step(0, 0, 0, 0, 0, 0, 0);
			repeat (8) begin
				a = 32'h100 + 4 * ($urandom % 32);
				if ($urandom % 2)
					ls_op(1, SZ_WORD, 0, a, $urandom);
				else
					ls_op(0, SZ_WORD, 0, a, 0);
			end
		join
		report_test("contention", e);

		e = errors;
		ls_op(0, SZ_HALF, 0, 32'h101, 0);
		ls_op(1, SZ_WORD, 0, 32'h102, 32'h1234_5678);
		ls_op(0, SZ_WORD, 0, 32'h400, 0);
		ls_op(1, SZ_BYTE, 0, 32'h500, 32'h55);
		fetch_step(0, 1, 0, 0, 32'h800, 0, 0);
		fetch_step(0, 1, 0, 0, 32'h0, 0, 0);
		wait_fetch();
		report_test("errors", e);

		$display("%0d tests, %0d failing, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/fetch_mem_top.sv ====
/*
 * Memory side of the core: fetch unit and load/store unit sharing one
 * memory slave through the arbiter. The execute stage drives the finish
 * strobe, the redirects and the load/store commands from outside.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_top
	import rv_mem_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            last_finish_i,
	input  logic            trap_i,
	input  logic [XLEN-1:0] trap_pc_i,
	input  logic            jump_i,
	input  logic [XLEN-1:0] jump_target_i,
	input  logic            branch_taken_i,
	input  logic [XLEN-1:0] branch_target_i,
	output logic            fetch_valid_o,
	output logic [XLEN-1:0] inst_o,
	output logic [XLEN-1:0] pc_o,
	output logic            inst_invalid_o,
	input  logic            ls_req_i,
	input  logic            ls_we_i,
	input  acc_size_e       ls_size_i,
	input  logic            ls_unsigned_i,
	input  logic [XLEN-1:0] ls_addr_i,
	input  logic [XLEN-1:0] ls_wdata_i,
	output logic            ls_busy_o,
	output logic            ls_done_o,
	output logic [XLEN-1:0] ls_rdata_o,
	output logic            ls_err_o
);

	logic              if_req_valid, if_req_ready, if_req_we;
	logic [XLEN-1:0]   if_req_addr, if_rsp_data;
	logic              if_rsp_valid, if_rsp_ready;
	logic [1:0]        if_rsp_resp;
	logic              ls_req_valid, ls_req_ready, ls_req_we;
	logic [XLEN-1:0]   ls_req_addr, ls_req_wdata, ls_rsp_data;
	logic [XLEN/8-1:0] ls_req_wstrb;
	logic              ls_rsp_valid, ls_rsp_ready;
	logic [1:0]        ls_rsp_resp;
	logic              m_req_valid, m_req_ready, m_req_we;
	logic [XLEN-1:0]   m_req_addr, m_req_wdata, m_rsp_data;
	logic [XLEN/8-1:0] m_req_wstrb;
	logic              m_rsp_valid, m_rsp_ready;
	logic [1:0]        m_rsp_resp;

	fetch_unit u_fetch (
		.clk             (clk),
		.rst             (rst),
		.last_finish_i   (last_finish_i),
		.trap_i          (trap_i),
		.trap_pc_i       (trap_pc_i),
		.jump_i          (jump_i),
		.jump_target_i   (jump_target_i),
		.branch_taken_i  (branch_taken_i),
		.branch_target_i (branch_target_i),
		.fetch_valid_o   (fetch_valid_o),
		.inst_o          (inst_o),
		.pc_o            (pc_o),
		.inst_invalid_o  (inst_invalid_o),
		.req_valid_o     (if_req_valid),
		.req_addr_o      (if_req_addr),
		.req_we_o        (if_req_we),
		.req_ready_i     (if_req_ready),
		.rsp_valid_i     (if_rsp_valid),
		.rsp_data_i      (if_rsp_data),
		.rsp_resp_i      (if_rsp_resp),
		.rsp_ready_o     (if_rsp_ready)
	);

	load_store_unit u_lsu (
		.clk           (clk),
		.rst           (rst),
		.ls_req_i      (ls_req_i),
		.ls_we_i       (ls_we_i),
		.ls_size_i     (ls_size_i),
		.ls_unsigned_i (ls_unsigned_i),
		.ls_addr_i     (ls_addr_i),
		.ls_wdata_i    (ls_wdata_i),
		.ls_busy_o     (ls_busy_o),
		.ls_done_o     (ls_done_o),
		.ls_rdata_o    (ls_rdata_o),
		.ls_err_o      (ls_err_o),
		.req_valid_o   (ls_req_valid),
		.req_we_o      (ls_req_we),
		.req_addr_o    (ls_req_addr),
		.req_wdata_o   (ls_req_wdata),
		.req_wstrb_o   (ls_req_wstrb),
		.req_ready_i   (ls_req_ready),
		.rsp_valid_i   (ls_rsp_valid),
		.rsp_data_i    (ls_rsp_data),
		.rsp_resp_i    (ls_rsp_resp),
		.rsp_ready_o   (ls_rsp_ready)
	);

	// fetch only reads, so its write lanes are tied off
	bus_arbiter u_arb (
		.clk            (clk),
		.rst            (rst),
		.if_req_valid_i (if_req_valid),
		.if_req_ready_o (if_req_ready),
		.if_req_we_i    (if_req_we),
		.if_req_addr_i  (if_req_addr),
		.if_req_wdata_i ('0),
		.if_req_wstrb_i ('0),
		.if_rsp_valid_o (if_rsp_valid),
		.if_rsp_ready_i (if_rsp_ready),
		.if_rsp_data_o  (if_rsp_data),
		.if_rsp_resp_o  (if_rsp_resp),
		.ls_req_valid_i (ls_req_valid),
		.ls_req_ready_o (ls_req_ready),
		.ls_req_we_i    (ls_req_we),
		.ls_req_addr_i  (ls_req_addr),
		.ls_req_wdata_i (ls_req_wdata),
		.ls_req_wstrb_i (ls_req_wstrb),
		.ls_rsp_valid_o (ls_rsp_valid),
		.ls_rsp_ready_i (ls_rsp_ready),
		.ls_rsp_data_o  (ls_rsp_data),
		.ls_rsp_resp_o  (ls_rsp_resp),
		.m_req_valid_o  (m_req_valid),
		.m_req_ready_i  (m_req_ready),
		.m_req_we_o     (m_req_we),
		.m_req_addr_o   (m_req_addr),
		.m_req_wdata_o  (m_req_wdata),
		.m_req_wstrb_o  (m_req_wstrb),
		.m_rsp_valid_i  (m_rsp_valid),
		.m_rsp_ready_o  (m_rsp_ready),
		.m_rsp_data_i   (m_rsp_data),
		.m_rsp_resp_i   (m_rsp_resp)
	);

	mem_slave u_mem (
		.clk           (clk),
		.rst           (rst),
		.m_req_valid_i (m_req_valid),
		.m_req_ready_o (m_req_ready),
		.m_req_we_i    (m_req_we),
		.m_req_addr_i  (m_req_addr),
		.m_req_wdata_i (m_req_wdata),
		.m_req_wstrb_i (m_req_wstrb),
		.m_rsp_valid_o (m_rsp_valid),
		.m_rsp_ready_i (m_rsp_ready),
		.m_rsp_data_o  (m_rsp_data),
		.m_rsp_resp_o  (m_rsp_resp)
	);

endmodule

`default_nettype wire

// ==== source/mem_slave.sv ====
/*
 * Single-ported word memory on the slave side of the bus. Contents come
 * from MEM_INIT_FILE and writes follow the byte strobes. A 16-bit LFSR
 * picks 0 to 3 cycles of delay for req_ready and for rsp_valid.
 * Out-of-range addresses get RESP_SLVERR with zero data and no write.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_slave
	import rv_mem_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              m_req_valid_i,
	output logic              m_req_ready_o,
	input  logic              m_req_we_i,
	input  logic [XLEN-1:0]   m_req_addr_i,
	input  logic [XLEN-1:0]   m_req_wdata_i,
	input  logic [XLEN/8-1:0] m_req_wstrb_i,
	output logic              m_rsp_valid_o,
	input  logic              m_rsp_ready_i,
	output logic [XLEN-1:0]   m_rsp_data_o,
	output logic [1:0]        m_rsp_resp_o
);

	typedef enum logic {
		ST_ACCEPT,
		ST_RESP
	} mem_state_e;

	logic [XLEN-1:0]           mem [MEM_WORDS];
	mem_state_e                state;
	logic [15:0]               lfsr;
	logic [MAX_DELAY_BITS-1:0] delay;
	logic [MAX_DELAY_BITS-1:0] wait_cnt;
	logic [MAX_DELAY_BITS-1:0] rsp_cnt;
	logic [MEM_IDX_BITS-1:0]   idx;
	logic                      in_range;
	logic                      req_fire;
	bus_resp_e                 rsp_resp;

	initial begin
		$readmemh(MEM_INIT_FILE, mem);
	end

	assign idx      = m_req_addr_i[MEM_IDX_BITS+1:2];
	assign in_range = (m_req_addr_i[XLEN-1:MEM_IDX_BITS+2] == '0);
	assign delay    = lfsr[MAX_DELAY_BITS-1:0];

	assign m_req_ready_o = (state == ST_ACCEPT) && m_req_valid_i && (wait_cnt == '0);
	assign m_rsp_valid_o = (state == ST_RESP) && (rsp_cnt == '0);
	assign m_rsp_resp_o  = rsp_resp;
	assign req_fire      = m_req_valid_i && m_req_ready_o;

	// taps 16, 14, 13, 11
	always_ff @(posedge clk) begin
		if (rst)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= ST_ACCEPT;
			wait_cnt <= '0;
			rsp_cnt  <= '0;
		end else if (state == ST_ACCEPT) begin
			if (req_fire) begin
				rsp_cnt <= delay;
				state   <= ST_RESP;
			end else if (m_req_valid_i) begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end else begin
			if (rsp_cnt != '0) begin
				rsp_cnt <= rsp_cnt - 1'b1;
			end else if (m_rsp_ready_i) begin
				// fresh ready delay for the next request
				wait_cnt <= delay;
				state    <= ST_ACCEPT;
			end
		end
	end

	// array access, read data is the word before any write
	always_ff @(posedge clk) begin
		if (req_fire) begin
			m_rsp_data_o <= in_range ? mem[idx] : '0;
			rsp_resp     <= in_range ? RESP_OKAY : RESP_SLVERR;
			if (in_range && m_req_we_i) begin
				for (int b = 0; b < XLEN/8; b++) begin
					if (m_req_wstrb_i[b])
						mem[idx][8*b +: 8] <= m_req_wdata_i[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/bus_arbiter.sv ====
/*
 * Two-master arbiter in front of the single-ported memory. While idle it
 * grants one requester, the load/store unit first. The owner is latched on
 * the request handshake and kept until the response handshake, so every
 * response is steered back to the master that asked for it.
 */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
	import rv_mem_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              if_req_valid_i,
	output logic              if_req_ready_o,
	input  logic              if_req_we_i,
	input  logic [XLEN-1:0]   if_req_addr_i,
	input  logic [XLEN-1:0]   if_req_wdata_i,
	input  logic [XLEN/8-1:0] if_req_wstrb_i,
	output logic              if_rsp_valid_o,
	input  logic              if_rsp_ready_i,
	output logic [XLEN-1:0]   if_rsp_data_o,
	output logic [1:0]        if_rsp_resp_o,
	input  logic              ls_req_valid_i,
	output logic              ls_req_ready_o,
	input  logic              ls_req_we_i,
	input  logic [XLEN-1:0]   ls_req_addr_i,
	input  logic [XLEN-1:0]   ls_req_wdata_i,
	input  logic [XLEN/8-1:0] ls_req_wstrb_i,
	output logic              ls_rsp_valid_o,
	input  logic              ls_rsp_ready_i,
	output logic [XLEN-1:0]   ls_rsp_data_o,
	output logic [1:0]        ls_rsp_resp_o,
	output logic              m_req_valid_o,
	input  logic              m_req_ready_i,
	output logic              m_req_we_o,
	output logic [XLEN-1:0]   m_req_addr_o,
	output logic [XLEN-1:0]   m_req_wdata_o,
	output logic [XLEN/8-1:0] m_req_wstrb_o,
	input  logic              m_rsp_valid_i,
	output logic              m_rsp_ready_o,
	input  logic [XLEN-1:0]   m_rsp_data_i,
	input  logic [1:0]        m_rsp_resp_i
);

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_IF,
		OWN_LS
	} bus_owner_e;

	bus_owner_e owner;
	bus_owner_e grant;
	logic       idle;

	assign idle  = (owner == OWN_NONE);
	assign grant = ls_req_valid_i ? OWN_LS : (if_req_valid_i ? OWN_IF : OWN_NONE);

	// request side follows the grant, only while nothing is outstanding
	assign m_req_valid_o  = idle && (grant != OWN_NONE);
	assign m_req_we_o     = (grant == OWN_LS) ? ls_req_we_i : if_req_we_i;
	assign m_req_addr_o   = (grant == OWN_LS) ? ls_req_addr_i : if_req_addr_i;
	assign m_req_wdata_o  = (grant == OWN_LS) ? ls_req_wdata_i : if_req_wdata_i;
	assign m_req_wstrb_o  = (grant == OWN_LS) ? ls_req_wstrb_i : if_req_wstrb_i;
	assign if_req_ready_o = idle && (grant == OWN_IF) && m_req_ready_i;
	assign ls_req_ready_o = idle && (grant == OWN_LS) && m_req_ready_i;

	// response side follows the latched owner
	assign if_rsp_valid_o = (owner == OWN_IF) && m_rsp_valid_i;
	assign ls_rsp_valid_o = (owner == OWN_LS) && m_rsp_valid_i;
	assign if_rsp_data_o  = (owner == OWN_IF) ? m_rsp_data_i : '0;
	assign ls_rsp_data_o  = (owner == OWN_LS) ? m_rsp_data_i : '0;
	assign if_rsp_resp_o  = (owner == OWN_IF) ? m_rsp_resp_i : RESP_OKAY;
	assign ls_rsp_resp_o  = (owner == OWN_LS) ? m_rsp_resp_i : RESP_OKAY;
	assign m_rsp_ready_o  = (owner == OWN_IF) ? if_rsp_ready_i :
		(owner == OWN_LS) ? ls_rsp_ready_i : 1'b0;

	always_ff @(posedge clk) begin
		if (rst)
			owner <= OWN_NONE;
		else if (m_req_valid_o && m_req_ready_i)
			owner <= grant;
		else if (m_rsp_valid_i && m_rsp_ready_o)
			owner <= OWN_NONE;
	end

	a_one_rsp: assert property (@(posedge clk) disable iff (rst)
		!(if_rsp_valid_o && ls_rsp_valid_o));

endmodule

`default_nettype wire

// ==== source/load_store_unit.sv ====
/*
 * Load/store unit for byte, half and word accesses. Requests go out word
 * aligned with byte strobes; load data is picked from its lane and sign or
 * zero extended. Misaligned accesses finish with ls_err_o set and never
 * touch the bus. ls_done_o pulses once per accepted ls_req_i.
 */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
	import rv_mem_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              ls_req_i,
	input  logic              ls_we_i,
	input  acc_size_e         ls_size_i,
	input  logic              ls_unsigned_i,
	input  logic [XLEN-1:0]   ls_addr_i,
	input  logic [XLEN-1:0]   ls_wdata_i,
	output logic              ls_busy_o,
	output logic              ls_done_o,
	output logic [XLEN-1:0]   ls_rdata_o,
	output logic              ls_err_o,
	output logic              req_valid_o,
	output logic              req_we_o,
	output logic [XLEN-1:0]   req_addr_o,
	output logic [XLEN-1:0]   req_wdata_o,
	output logic [XLEN/8-1:0] req_wstrb_o,
	input  logic              req_ready_i,
	input  logic              rsp_valid_i,
	input  logic [XLEN-1:0]   rsp_data_i,
	input  logic [1:0]        rsp_resp_i,
	output logic              rsp_ready_o
);

	typedef enum logic [2:0] {
		LS_IDLE,
		LS_REQ,
		LS_WAIT,
		LS_MISALIGN,
		LS_DONE
	} ls_state_e;

	ls_state_e       state;
	acc_size_e       size_q;
	logic            unsigned_q;
	logic [1:0]      off_q;
	logic            misaligned;
	logic            accept;
	logic [XLEN-1:0] lane;
	logic [XLEN-1:0] load_val;

	assign accept     = ls_req_i && !ls_busy_o;
	assign misaligned = ((ls_size_i == SZ_HALF) && ls_addr_i[0]) ||
		((ls_size_i == SZ_WORD) && (ls_addr_i[1:0] != 2'b00));

	assign ls_busy_o   = (state != LS_IDLE);
	assign ls_done_o   = (state == LS_DONE);
	assign req_valid_o = (state == LS_REQ);
	assign rsp_ready_o = (state == LS_WAIT);

	// bring the addressed lane down to bit 0, then extend
	assign lane = rsp_data_i >> {off_q, 3'b000};

	always_comb begin
		case (size_q)
			SZ_BYTE: load_val = unsigned_q ? {{(XLEN-8){1'b0}}, lane[7:0]} :
				{{(XLEN-8){lane[7]}}, lane[7:0]};
			SZ_HALF: load_val = unsigned_q ? {{(XLEN-16){1'b0}}, lane[15:0]} :
				{{(XLEN-16){lane[15]}}, lane[15:0]};
			default: load_val = rsp_data_i;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= LS_IDLE;
			ls_rdata_o <= '0;
			ls_err_o   <= 1'b0;
		end else begin
			case (state)
				LS_IDLE: begin
					if (accept) begin
						state      <= misaligned ? LS_MISALIGN : LS_REQ;
						ls_rdata_o <= '0;
						ls_err_o   <= 1'b0;
					end
				end
				LS_REQ: begin
					if (req_ready_i)
						state <= LS_WAIT;
				end
				LS_WAIT: begin
					if (rsp_valid_i) begin
						ls_err_o   <= (rsp_resp_i != RESP_OKAY);
						ls_rdata_o <= (rsp_resp_i != RESP_OKAY || req_we_o) ? '0 : load_val;
						state      <= LS_DONE;
					end
				end
				LS_MISALIGN: begin
					ls_err_o <= 1'b1;
					state    <= LS_DONE;
				end
				default: begin
					state <= LS_IDLE;
				end
			endcase
		end
	end

	// request payload, captured with the command
	always_ff @(posedge clk) begin
		if (accept) begin
			size_q      <= ls_size_i;
			unsigned_q  <= ls_unsigned_i;
			off_q       <= ls_addr_i[1:0];
			req_we_o    <= ls_we_i;
			req_addr_o  <= {ls_addr_i[XLEN-1:2], 2'b00};
			req_wdata_o <= ls_wdata_i << {ls_addr_i[1:0], 3'b000};
			case (ls_size_i)
				SZ_BYTE: req_wstrb_o <= 4'b0001 << ls_addr_i[1:0];
				SZ_HALF: req_wstrb_o <= 4'b0011 << ls_addr_i[1:0];
				default: req_wstrb_o <= 4'b1111;
			endcase
		end
	end

	a_misalign_quiet: assert property (@(posedge clk) disable iff (rst)
		accept && misaligned |=> !req_valid_o ##1 (!req_valid_o && ls_done_o && ls_err_o));

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
/*
 * Instruction fetch unit. Holds the PC, reads one word per instruction over
 * the shared request/response bus and presents it with a one-cycle
 * fetch_valid_o pulse. Then waits for last_finish_i from execute, which
 * also selects the next PC from trap, jump, branch or pc + 4.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
	import rv_mem_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            last_finish_i,
	input  logic            trap_i,
	input  logic [XLEN-1:0] trap_pc_i,
	input  logic            jump_i,
	input  logic [XLEN-1:0] jump_target_i,
	input  logic            branch_taken_i,
	input  logic [XLEN-1:0] branch_target_i,
	output logic            fetch_valid_o,
	output logic [XLEN-1:0] inst_o,
	output logic [XLEN-1:0] pc_o,
	output logic            inst_invalid_o,
	output logic            req_valid_o,
	output logic [XLEN-1:0] req_addr_o,
	output logic            req_we_o,
	input  logic            req_ready_i,
	input  logic            rsp_valid_i,
	input  logic [XLEN-1:0] rsp_data_i,
	input  logic [1:0]      rsp_resp_i,
	output logic            rsp_ready_o
);

	typedef enum logic [1:0] {
		REQ,
		WAIT_RSP,
		DELIVER,
		WAIT_FINISH
	} fetch_state_e;

	fetch_state_e    state;
	logic            legal;
	logic            rsp_err;
	logic [XLEN-1:0] next_pc;
	// address of the word in flight, pc_o takes it on delivery
	logic [XLEN-1:0] fetch_pc;

	rv32_legal_check u_legal (
		.inst_i  (rsp_data_i),
		.legal_o (legal)
	);

	assign rsp_err = (rsp_resp_i != RESP_OKAY);

	// redirect priority: trap, jump, taken branch, sequential
	assign next_pc = trap_i ? trap_pc_i :
		jump_i ? jump_target_i :
		branch_taken_i ? branch_target_i :
		pc_o + 32'd4;

	assign req_addr_o    = fetch_pc;
	assign req_we_o      = 1'b0;
	assign rsp_ready_o   = (state == WAIT_RSP);
	assign fetch_valid_o = (state == DELIVER);

	always_ff @(posedge clk) begin
		if (rst) begin
			state          <= REQ;
			req_valid_o    <= 1'b0;
			pc_o           <= RESET_PC;
			fetch_pc       <= RESET_PC;
			inst_invalid_o <= 1'b0;
		end else begin
			case (state)
				REQ: begin
					// first cycle after reset raises the request
					if (!req_valid_o) begin
						req_valid_o <= 1'b1;
					end else if (req_ready_i) begin
						req_valid_o <= 1'b0;
						state       <= WAIT_RSP;
					end
				end
				WAIT_RSP: begin
					if (rsp_valid_i) begin
						inst_invalid_o <= rsp_err | ~legal;
						pc_o           <= fetch_pc;
						state          <= DELIVER;
					end
				end
				DELIVER: begin
					state <= WAIT_FINISH;
				end
				WAIT_FINISH: begin
					if (last_finish_i) begin
						fetch_pc    <= next_pc;
						req_valid_o <= 1'b1;
						state       <= REQ;
					end
				end
				default: begin
					state <= REQ;
				end
			endcase
		end
	end

	// instruction register, zero on a bus error
	always_ff @(posedge clk) begin
		if (state == WAIT_RSP && rsp_valid_i)
			inst_o <= rsp_err ? '0 : rsp_data_i;
	end

	a_addr_stable: assert property (@(posedge clk) disable iff (rst)
		req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_addr_o));

endmodule

`default_nettype wire

// ==== source/rv32_legal_check.sv ====
/*
 * Combinational legality check for fetched instruction words.
 * legal_o is high only for the supported RV32I subset: U/J types, JALR,
 * branches, the five loads, three stores, OP-IMM with valid shift forms,
 * any OP, CSRRW/CSRRS and the exact ECALL, EBREAK and MRET words.
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_legal_check
	import rv_mem_pkg::*;
(
	input  logic [XLEN-1:0] inst_i,
	output logic            legal_o
);

	logic [2:0] f3;
	logic [6:0] f7;

	assign f3 = inst_i[14:12];
	assign f7 = inst_i[31:25];

	always_comb begin
		legal_o = 1'b0;
		case (inst_i[6:0])
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_BRANCH, OPC_OP: begin
				legal_o = 1'b1;
			end
			OPC_JALR: begin
				legal_o = (f3 == F3_JALR);
			end
			OPC_LOAD: begin
				legal_o = f3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
			end
			OPC_STORE: begin
				legal_o = f3 inside {F3_SB, F3_SH, F3_SW};
			end
			OPC_OP_IMM: begin
				// shifts carry their kind in the upper immediate bits
				if (f3 == F3_SLLI)
					legal_o = (f7 == F7_SHIFT_LOG);
				else if (f3 == F3_SRLI_SRAI)
					legal_o = (f7 == F7_SHIFT_LOG) || (f7 == F7_SHIFT_ARI);
				else
					legal_o = 1'b1;
			end
			OPC_SYSTEM: begin
				legal_o = (f3 == F3_CSRRW) || (f3 == F3_CSRRS) ||
					(inst_i == ECALL_WORD) || (inst_i == EBREAK_WORD) ||
					(inst_i == MRET_WORD);
			end
			default: begin
				legal_o = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/rv_mem_pkg.sv ====
/*
 * Shared constants and types for the fetch / load-store memory subsystem.
 * Bus widths, memory geometry, LFSR seed, RV32I opcodes and funct3 codes,
 * plus the access size and response encodings. Modules pull these in with
 * a wildcard import in their header.
 */
`default_nettype none

package rv_mem_pkg;

	localparam int XLEN           = 32;
	localparam int MEM_WORDS      = 256;
	localparam int MEM_IDX_BITS   = $clog2(MEM_WORDS);
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
	localparam int MAX_DELAY_BITS = 2;
	localparam logic [15:0] LFSR_SEED = 16'hace1;
	localparam string MEM_INIT_FILE = "verification/program.hex";

	// rv32i major opcodes
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// whole-word system encodings
	localparam logic [XLEN-1:0] ECALL_WORD  = 32'h0000_0073;
	localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;
	localparam logic [XLEN-1:0] MRET_WORD   = 32'h3020_0073;

	localparam logic [2:0] F3_JALR      = 3'b000;
	localparam logic [2:0] F3_LB        = 3'b000;
	localparam logic [2:0] F3_LH        = 3'b001;
	localparam logic [2:0] F3_LW        = 3'b010;
	localparam logic [2:0] F3_LBU       = 3'b100;
	localparam logic [2:0] F3_LHU       = 3'b101;
	localparam logic [2:0] F3_SB        = 3'b000;
	localparam logic [2:0] F3_SH        = 3'b001;
	localparam logic [2:0] F3_SW        = 3'b010;
	localparam logic [2:0] F3_SLLI      = 3'b001;
	localparam logic [2:0] F3_SRLI_SRAI = 3'b101;
	localparam logic [6:0] F7_SHIFT_LOG = 7'b0000000;
	localparam logic [6:0] F7_SHIFT_ARI = 7'b0100000;
	localparam logic [2:0] F3_CSRRW     = 3'b001;
	localparam logic [2:0] F3_CSRRS     = 3'b010;

	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_HALF = 2'd1,
		SZ_WORD = 2'd2
	} acc_size_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} bus_resp_e;

endpackage

`default_nettype wire
